// File: build.f
source/agu_pkg.sv
source/agu_cfg_regs.sv
source/agu_addr_gen.sv
source/agu_data_mem.sv
source/agu_stream_out.sv
source/agu_engine_top.sv
verification/agu_engine_tb_assert.sv
verification/agu_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the address engine testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
   --timescale 1ns/100ps \
   --top-module agu_engine_tb \
   -f build.f \
   -o agu_engine_sim

./obj_dir/agu_engine_sim | tee "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
   echo "simulation reported failure, see $LOG"
   exit 1
fi
echo "simulation finished without failure"

// File: source/agu_addr_gen.sv
module agu_addr_gen (
   input  logic               clk,
   input  logic               rst,
   input  logic               init,
   input  logic               run,
   input  logic               pause,
   input  agu_pkg::agu_cfg_t  cfg,
   output logic               rd_en,
   output agu_pkg::addr_t     rd_addr,
   output logic               done
);

   agu_pkg::gen_state_e state, state_nxt;

   agu_pkg::addr_t   addr, addr_nxt;     // running address
   agu_pkg::addr_t   iter, iter_nxt;     // current period index
   agu_pkg::period_t pos, pos_nxt;       // position inside the period
   agu_pkg::period_t dly_cnt, dly_nxt;

   logic run_pend;     // run seen while the pattern was still going
   logic start_req;
   logic start_go;
   logic period_end;

   // sanitized pattern limits
   agu_pkg::period_t duty_lim, duty_eff, period_eff;
   agu_pkg::period_t duty_last, period_last;
   agu_pkg::addr_t   iter_last;
   agu_pkg::addr_t   step_in, step_wrap;

   assign duty_lim    = (cfg.duty > cfg.period) ? cfg.period : cfg.duty;
   assign duty_eff    = (duty_lim == '0) ? agu_pkg::period_t'(1) : duty_lim;
   assign period_eff  = (cfg.period < duty_eff) ? duty_eff : cfg.period;
   assign duty_last   = duty_eff - 1'b1;
   assign period_last = period_eff - 1'b1;
   assign iter_last   = (cfg.iterations == '0) ? '0 : cfg.iterations - 1'b1;

   // modulo 2^ADDR_W steps
   assign step_in   = agu_pkg::addr_t'(cfg.incr);
   assign step_wrap = agu_pkg::addr_t'(cfg.incr + cfg.shift);

   assign start_req = run | run_pend;

   always_comb begin
      state_nxt  = state;
      addr_nxt   = addr;
      iter_nxt   = iter;
      pos_nxt    = pos;
      dly_nxt    = dly_cnt;
      start_go   = 1'b0;
      period_end = 1'b0;

      case (state)
         agu_pkg::GEN_IDLE: begin
            if (init) begin
               addr_nxt = cfg.start;
               iter_nxt = '0;
               pos_nxt  = '0;
            end
            start_go = start_req;
         end
         agu_pkg::GEN_DELAY: begin
            dly_nxt = dly_cnt - 1'b1;
            if (dly_cnt == agu_pkg::period_t'(1))
               state_nxt = agu_pkg::GEN_ACTIVE;
         end
         agu_pkg::GEN_ACTIVE: begin
            pos_nxt  = pos + 1'b1;
            addr_nxt = addr + step_in;
            if (pos == duty_last) begin
               addr_nxt = addr + step_wrap; // first address of next period
               if (period_eff != duty_eff)
                  state_nxt = agu_pkg::GEN_GAP;
               else
                  period_end = 1'b1;
            end
         end
         agu_pkg::GEN_GAP: begin
            pos_nxt = pos + 1'b1;
            if (pos == period_last)
               period_end = 1'b1;
         end
         default: begin
            state_nxt = agu_pkg::GEN_IDLE;
         end
      endcase

      if (period_end) begin
         pos_nxt = '0;
         if (iter == iter_last) begin
            state_nxt = agu_pkg::GEN_IDLE;
            start_go  = start_req; // back to back restart
         end else begin
            iter_nxt  = iter + 1'b1;
            state_nxt = agu_pkg::GEN_ACTIVE;
         end
      end

      if (start_go) begin
         addr_nxt  = cfg.start;
         iter_nxt  = '0;
         pos_nxt   = '0;
         dly_nxt   = cfg.delay;
         state_nxt = (cfg.delay == '0) ? agu_pkg::GEN_ACTIVE : agu_pkg::GEN_DELAY;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= agu_pkg::GEN_IDLE;
         addr     <= '0;
         iter     <= '0;
         pos      <= '0;
         dly_cnt  <= '0;
         run_pend <= 1'b0;
      end else begin
         // a start only counts when the step is not paused
         if (start_go && !pause)
            run_pend <= 1'b0;
         else if (run)
            run_pend <= 1'b1;

         if (!pause) begin
            state   <= state_nxt;
            addr    <= addr_nxt;
            iter    <= iter_nxt;
            pos     <= pos_nxt;
            dly_cnt <= dly_nxt;
         end
      end
   end

   assign rd_en   = (state == agu_pkg::GEN_ACTIVE);
   assign rd_addr = addr;
   assign done    = (state == agu_pkg::GEN_IDLE);

endmodule

// File: source/agu_cfg_regs.sv
module agu_cfg_regs (
   input  logic               clk,
   input  logic               rst,
   input  logic               cfg_wr,
   input  agu_pkg::cfg_reg_e  cfg_sel,
   input  logic [15:0]        cfg_wdata,
   output agu_pkg::agu_cfg_t  cfg,
   output logic               init,
   output logic               run
);

   // field views of the write data, upper bits dropped
   agu_pkg::addr_t   wdata_addr;
   agu_pkg::period_t wdata_period;
   agu_pkg::offset_t wdata_offset;

   assign wdata_addr   = cfg_wdata[agu_pkg::ADDR_W-1:0];
   assign wdata_period = cfg_wdata[agu_pkg::PERIOD_W-1:0];
   assign wdata_offset = agu_pkg::offset_t'(cfg_wdata[agu_pkg::ADDR_W-1:0]);

   always_ff @(posedge clk) begin
      if (rst) begin
         cfg  <= '0;
         init <= 1'b0;
         run  <= 1'b0;
      end else begin
         init <= 1'b0; // pulses last one cycle
         run  <= 1'b0;
         if (cfg_wr) begin
            case (cfg_sel)
               agu_pkg::REG_ITER: begin
                  cfg.iterations <= wdata_addr;
               end
               agu_pkg::REG_PERIOD: begin
                  cfg.period <= wdata_period;
               end
               agu_pkg::REG_DUTY: begin
                  cfg.duty <= wdata_period;
               end
               agu_pkg::REG_DELAY: begin
                  cfg.delay <= wdata_period;
               end
               agu_pkg::REG_START: begin
                  cfg.start <= wdata_addr;
               end
               agu_pkg::REG_SHIFT: begin
                  cfg.shift <= wdata_offset;
               end
               agu_pkg::REG_INCR: begin
                  cfg.incr <= wdata_offset;
               end
               agu_pkg::REG_CMD: begin
                  init <= cfg_wdata[0];
                  run  <= cfg_wdata[1];
               end
               default: begin
                  init <= 1'b0;
               end
            endcase
         end
      end
   end

endmodule

// File: source/agu_data_mem.sv
module agu_data_mem (
   input  logic            clk,
   input  logic            wr,
   input  agu_pkg::addr_t  wr_addr,
   input  agu_pkg::data_t  wr_data,
   input  logic            rd,
   input  agu_pkg::addr_t  rd_addr,
   output agu_pkg::data_t  rd_data
);

   localparam int DEPTH = 2 ** agu_pkg::ADDR_W;

   agu_pkg::data_t mem [DEPTH];

   // host load port
   always_ff @(posedge clk) begin
      if (wr)
         mem[wr_addr] <= wr_data;
   end

   // engine read, one cycle latency, holds when not enabled
   always_ff @(posedge clk) begin
      if (rd)
         rd_data <= mem[rd_addr];
   end

endmodule

// File: source/agu_engine_top.sv
module agu_engine_top #(
   parameter int unsigned CREDITS = 4
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                cfg_wr,
   input  agu_pkg::cfg_reg_e   cfg_sel,
   input  logic [15:0]         cfg_wdata,
   input  logic                mem_wr,
   input  agu_pkg::addr_t      mem_wr_addr,
   input  agu_pkg::data_t      mem_wr_data,
   input  logic                credit_return,
   output logic                out_valid,
   output agu_pkg::out_word_t  out_word,
   output logic                done
);

   agu_pkg::agu_cfg_t cfg;
   logic              init;
   logic              run;
   logic              pause;
   logic              rd_en;
   agu_pkg::addr_t    rd_addr;
   logic              mem_rd;
   agu_pkg::data_t    rd_data;

   agu_cfg_regs i_agu_cfg_regs (
      .clk       (clk),
      .rst       (rst),
      .cfg_wr    (cfg_wr),
      .cfg_sel   (cfg_sel),
      .cfg_wdata (cfg_wdata),
      .cfg       (cfg),
      .init      (init),
      .run       (run)
   );

   agu_addr_gen i_agu_addr_gen (
      .clk     (clk),
      .rst     (rst),
      .init    (init),
      .run     (run),
      .pause   (pause),
      .cfg     (cfg),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .done    (done)
   );

   agu_data_mem i_agu_data_mem (
      .clk     (clk),
      .wr      (mem_wr),
      .wr_addr (mem_wr_addr),
      .wr_data (mem_wr_data),
      .rd      (mem_rd),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   agu_stream_out #(
      .CREDITS (CREDITS)
   ) i_agu_stream_out (
      .clk           (clk),
      .rst           (rst),
      .rd_en         (rd_en),
      .rd_addr       (rd_addr),
      .mem_rd        (mem_rd),
      .rd_data       (rd_data),
      .credit_return (credit_return),
      .pause         (pause),
      .out_valid     (out_valid),
      .out_word      (out_word)
   );

endmodule

// File: source/agu_pkg.sv
package agu_pkg;

   localparam int ADDR_W   = 10;   // memory address and iteration count
   localparam int PERIOD_W = 10;   // period, duty, delay
   localparam int DATA_W   = 32;

   typedef logic        [ADDR_W-1:0]   addr_t;
   typedef logic signed [ADDR_W-1:0]   offset_t;
   typedef logic        [PERIOD_W-1:0] period_t;
   typedef logic        [DATA_W-1:0]   data_t;

   // one access pattern as programmed by the host
   typedef struct packed {
      addr_t   iterations;
      period_t period;
      period_t duty;
      period_t delay;
      addr_t   start;
      offset_t shift;
      offset_t incr;
   } agu_cfg_t;

   // register select, REG_CMD bit 0 is init and bit 1 is run
   typedef enum logic [2:0] {
      REG_ITER,
      REG_PERIOD,
      REG_DUTY,
      REG_DELAY,
      REG_START,
      REG_SHIFT,
      REG_INCR,
      REG_CMD
   } cfg_reg_e;

   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_DELAY,
      GEN_ACTIVE,
      GEN_GAP
   } gen_state_e;

   typedef struct packed {
      data_t data;
      addr_t addr;
   } out_word_t;

endpackage

// File: source/agu_stream_out.sv
module agu_stream_out #(
   parameter int unsigned CREDITS = 4
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                rd_en,
   input  agu_pkg::addr_t      rd_addr,
   output logic                mem_rd,
   input  agu_pkg::data_t      rd_data,
   input  logic                credit_return,
   output logic                pause,
   output logic                out_valid,
   output agu_pkg::out_word_t  out_word
);

   localparam int CNT_W = $clog2(CREDITS + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CREDITS);

   logic [CNT_W-1:0] credits;   // credits still available
   logic             issue;
   logic             valid_q;
   agu_pkg::addr_t   addr_q;    // issued address, waits for its data

   assign issue  = rd_en && !pause;
   assign mem_rd = issue;
   assign pause  = (credits == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         credits <= CNT_MAX;
      end else begin
         case ({issue, credit_return})
            2'b10: begin
               credits <= credits - 1'b1;
            end
            2'b01: begin
               if (credits != CNT_MAX)
                  credits <= credits + 1'b1; // ignore extra returns
            end
            default: begin
               credits <= credits; // both or neither
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         valid_q <= 1'b0;
      else
         valid_q <= issue;
   end

   always_ff @(posedge clk) begin
      if (issue)
         addr_q <= rd_addr;
   end

   // data arrives from the memory register in the same cycle
   assign out_valid     = valid_q;
   assign out_word.data = rd_data;
   assign out_word.addr = addr_q;

endmodule

// File: verification/agu_engine_tb.sv
module agu_engine_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CREDITS   = 4;
   localparam int MEM_WORDS = 2 ** agu_pkg::ADDR_W;
   localparam logic [15:0] SEED = 16'd39;

   logic               clk = 1'b0;
   logic               rst;
   logic               cfg_wr;
   agu_pkg::cfg_reg_e  cfg_sel;
   logic [15:0]        cfg_wdata;
   logic               mem_wr;
   agu_pkg::addr_t     mem_wr_addr;
   agu_pkg::data_t     mem_wr_data;
   logic               credit_return = 1'b0;
   logic               out_valid;
   agu_pkg::out_word_t out_word;
   logic               done;

   agu_pkg::data_t     mem_model [MEM_WORDS];   // copy of what the host loaded
   agu_pkg::out_word_t rx_q [$];
   agu_pkg::addr_t     exp_q [$];
   int                 rx_base;
   logic [15:0]        fill_lfsr;
   logic [15:0]        pace_lfsr = SEED;        // consumer pacing
   logic               slow_mode;
   int                 owed = 0;                // words whose credit is not back
   int                 gap_cnt = 0;
   int                 errors = 0;
   int                 consumer_errors = 0;
   int                 tests_run = 0;
   int                 tests_failed = 0;
   logic               done_q = 1'b1;
   int                 done_rises = 0;

   agu_engine_top #(
      .CREDITS (CREDITS)
   ) i_agu_engine_top (
      .clk           (clk),
      .rst           (rst),
      .cfg_wr        (cfg_wr),
      .cfg_sel       (cfg_sel),
      .cfg_wdata     (cfg_wdata),
      .mem_wr        (mem_wr),
      .mem_wr_addr   (mem_wr_addr),
      .mem_wr_data   (mem_wr_data),
      .credit_return (credit_return),
      .out_valid     (out_valid),
      .out_word      (out_word),
      .done          (done)
   );

   always #2 clk = ~clk;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(inout logic [15:0] state, input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         state = lfsr_next(state);
         v = {v[30:0], state[0]};
      end
   endtask

   function automatic int error_count();
      return errors + consumer_errors;
   endfunction

   // consumer returns one credit per word
   always @(negedge clk) begin
      logic [31:0] r;
      credit_return = 1'b0;
      if (!rst) begin
         if (gap_cnt != 0)
            gap_cnt--;
         if (owed != 0 && (!slow_mode || gap_cnt == 0)) begin
            credit_return = 1'b1;
            owed--;
            if (slow_mode) begin
               rand_bits(pace_lfsr, 2, r);
               gap_cnt = 2 + int'(r[1:0]);
            end
         end
         if (out_valid) begin
            rx_q.push_back(out_word);
            owed++;
            if (owed > CREDITS) begin
               $display("at %0t more than %0d words arrived without a credit back",
                        $time, CREDITS);
               consumer_errors++;
            end
         end
      end
   end

   always @(negedge clk) begin
      if (done && !done_q)
         done_rises++;
      done_q = done;
   end

   task automatic check_word(input string name, input agu_pkg::out_word_t got,
                             input agu_pkg::out_word_t exp);
      if (got !== exp) begin
         $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input agu_pkg::addr_t got,
                             input agu_pkg::addr_t exp);
      if (got !== exp) begin
         $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic write_reg(input agu_pkg::cfg_reg_e sel, input logic [15:0] data);
      @(negedge clk);
      cfg_wr    = 1'b1;
      cfg_sel   = sel;
      cfg_wdata = data;
      @(negedge clk);
      cfg_wr = 1'b0;
   endtask

   task automatic load_mem();
      logic [31:0] w;
      for (int a = 0; a < MEM_WORDS; a++) begin
         rand_bits(fill_lfsr, 32, w);
         w = w ^ {a[15:0], a[15:0]};
         mem_model[a] = w;
         @(negedge clk);
         mem_wr      = 1'b1;
         mem_wr_addr = agu_pkg::addr_t'(a);
         mem_wr_data = w;
      end
      @(negedge clk);
      mem_wr = 1'b0;
   endtask

   task automatic start_run();
      write_reg(agu_pkg::REG_CMD, 16'h0003);   // init and run
   endtask

   function automatic agu_pkg::agu_cfg_t make_pattern(input int iters, input int period,
         input int duty, input int delay, input int start, input int shift, input int incr);
      agu_pkg::agu_cfg_t pat;
      pat.iterations = agu_pkg::addr_t'(iters);
      pat.period     = agu_pkg::period_t'(period);
      pat.duty       = agu_pkg::period_t'(duty);
      pat.delay      = agu_pkg::period_t'(delay);
      pat.start      = agu_pkg::addr_t'(start);
      pat.shift      = agu_pkg::offset_t'(shift);
      pat.incr       = agu_pkg::offset_t'(incr);
      return pat;
   endfunction

   task automatic program_pattern(input agu_pkg::agu_cfg_t pat);
      write_reg(agu_pkg::REG_ITER, 16'(pat.iterations));
      write_reg(agu_pkg::REG_PERIOD, 16'(pat.period));
      write_reg(agu_pkg::REG_DUTY, 16'(pat.duty));
      write_reg(agu_pkg::REG_DELAY, 16'(pat.delay));
      write_reg(agu_pkg::REG_START, 16'(pat.start));
      write_reg(agu_pkg::REG_SHIFT, 16'(pat.shift));
      write_reg(agu_pkg::REG_INCR, 16'(pat.incr));
   endtask

   // expected addresses of one full pattern
   task automatic expand_pattern(input agu_pkg::agu_cfg_t pat);
      int d;
      int n;
      int base;
      d = (pat.duty > pat.period) ? int'(pat.period) : int'(pat.duty);
      if (d == 0)
         d = 1;
      n = (pat.iterations == '0) ? 1 : int'(pat.iterations);
      for (int k = 0; k < n; k++) begin
         base = int'(pat.start) + k * (d * int'(pat.incr) + int'(pat.shift));
         for (int j = 0; j < d; j++)
            exp_q.push_back(agu_pkg::addr_t'(base + j * int'(pat.incr)));
      end
   endtask

   task automatic wait_done(input logic level, input int limit);
      int n;
      n = 0;
      while (done !== level && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (done !== level) begin
         $display("timeout at %0t: done did not go to %0b in %0d cycles", $time, level, limit);
         errors++;
      end
   endtask

   task automatic wait_words(input int count, input int limit);
      int n;
      n = 0;
      while (rx_q.size() - rx_base < count && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (rx_q.size() - rx_base < count) begin
         $display("timeout at %0t: only %0d of %0d words arrived", $time,
                  rx_q.size() - rx_base, count);
         errors++;
      end
   endtask

   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      while (owed != 0 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (owed != 0) begin
         $display("timeout at %0t: %0d credits never went back", $time, owed);
         errors++;
      end
   endtask

   task automatic compare_stream();
      agu_pkg::out_word_t exp_word;
      int got_n;
      got_n = rx_q.size() - rx_base;
      if (got_n != exp_q.size()) begin
         $display("at %0t received %0d words but expected %0d", $time, got_n, exp_q.size());
         errors++;
      end
      for (int i = 0; i < got_n && i < exp_q.size(); i++) begin
         exp_word.addr = exp_q[i];
         exp_word.data = mem_model[exp_q[i]];
         check_addr("out_word.addr", rx_q[rx_base + i].addr, exp_q[i]);
         check_word("out_word", rx_q[rx_base + i], exp_word);
      end
   endtask

   task automatic begin_test();
      rx_base = rx_q.size();
      exp_q.delete();
   endtask

   task automatic report_test(input string name, input int err0);
      tests_run++;
      if (error_count() == err0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, error_count() - err0);
      end
   endtask

   task automatic run_pattern(input agu_pkg::agu_cfg_t pat, input int limit);
      begin_test();
      program_pattern(pat);
      expand_pattern(pat);
      start_run();
      wait_done(1'b0, 10);
      wait_done(1'b1, limit);
      wait_words(exp_q.size(), 50);
      wait_drained(100);
      compare_stream();
   endtask

   task automatic test_reset_idle();
      int err0;
      err0 = error_count();
      check_flag("done", done, 1'b1);
      repeat (20) begin
         @(negedge clk);
         check_flag("out_valid", out_valid, 1'b0);
      end
      report_test("reset and idle", err0);
   endtask

   task automatic test_contiguous_burst();
      int err0;
      err0 = error_count();
      run_pattern(make_pattern(1, 8, 8, 0, 100, 0, 1), 200);
      report_test("contiguous burst", err0);
   endtask

   task automatic test_strided_pattern();
      int err0;
      err0 = error_count();
      run_pattern(make_pattern(3, 7, 3, 5, 1020, -20, 2), 400);   // wraps past 1023
      check_flag("done", done, 1'b1);
      report_test("strided 2-D pattern", err0);
   endtask

   task automatic test_back_pressure();
      int err0;
      err0 = error_count();
      slow_mode = 1'b1;
      run_pattern(make_pattern(4, 10, 10, 1, 500, 5, 3), 3000);
      slow_mode = 1'b0;
      report_test("back-pressure", err0);
   endtask

   task automatic test_back_to_back();
      agu_pkg::agu_cfg_t pat;
      int err0;
      int rises0;
      err0   = error_count();
      pat    = make_pattern(3, 6, 4, 2, 40, 1, 3);
      begin_test();
      program_pattern(pat);
      expand_pattern(pat);
      expand_pattern(pat);
      rises0 = done_rises;
      start_run();
      wait_done(1'b0, 10);
      repeat (6) @(negedge clk);    // well inside the first pattern
      check_flag("done", done, 1'b0);
      start_run();
      wait_words(exp_q.size(), 400);
      wait_done(1'b1, 50);
      wait_drained(100);
      @(negedge clk);
      compare_stream();
      if (done_rises - rises0 != 1) begin
         $display("done rose %0d times during the two runs instead of once",
                  done_rises - rises0);
         errors++;
      end
      report_test("back-to-back run", err0);
   endtask

   initial begin
      rst         = 1'b1;
      cfg_wr      = 1'b0;
      cfg_sel     = agu_pkg::REG_ITER;
      cfg_wdata   = '0;
      mem_wr      = 1'b0;
      mem_wr_addr = '0;
      mem_wr_data = '0;
      slow_mode   = 1'b0;
      fill_lfsr   = SEED;
      rx_base     = 0;
      repeat (16) @(negedge clk);
      rst = 1'b0;

      test_reset_idle();
      load_mem();
      test_contiguous_burst();
      test_strided_pattern();
      test_back_pressure();
      test_back_to_back();

      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count());
      if (error_count() == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: verification/agu_engine_tb_assert.sv
module agu_engine_tb_assert #(
   parameter int unsigned CREDITS = 4
) (
   input logic clk,
   input logic rst,
   input logic mem_rd,
   input logic pause,
   input logic credit_return,
   input logic out_valid
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned outstanding;   // reads issued whose credit is not back yet

   always_ff @(posedge clk) begin
      if (rst)
         outstanding <= 0;
      else if (mem_rd && !credit_return)
         outstanding <= outstanding + 1;
      else if (!mem_rd && credit_return && outstanding != 0)
         outstanding <= outstanding - 1;
   end

   a_credit_limit: assert property (@(posedge clk) disable iff (rst) outstanding <= CREDITS)
      else $error("more reads outstanding than credits");

   a_valid_after_issue: assert property (@(posedge clk) disable iff (rst)
      out_valid == $past(mem_rd))
      else $error("out_valid does not follow a read issue by one cycle");

   a_no_read_in_pause: assert property (@(posedge clk) disable iff (rst)
      (outstanding == CREDITS) |-> (pause && !mem_rd))
      else $error("read issued or pause low with no credit left");

endmodule

bind agu_stream_out agu_engine_tb_assert #(
   .CREDITS (CREDITS)
) i_agu_engine_tb_assert (
   .clk           (clk),
   .rst           (rst),
   .mem_rd        (mem_rd),
   .pause         (pause),
   .credit_return (credit_return),
   .out_valid     (out_valid)
);
